// File: Makefile
TOP := bat_amateur_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
hdl/bat_pkg.sv
hdl/bat_alu.sv
hdl/bat_regfile.sv
hdl/bat_memory.sv
hdl/bat_controller.sv
hdl/bat_amateur.sv
verif/bat_amateur_assertions.sv
verif/bat_amateur_tb.sv

// File: hdl/bat_alu.sv
`timescale 1ns/10ps
`default_nettype none

module bat_alu import bat_pkg::*; (
    input  wire logic [DATA_W-1:0] a,
    input  wire logic [DATA_W-1:0] b,
    input  wire opcode_e           op,
    output logic [DATA_W-1:0]      result,
    output flags_t                 flags
);

    // top bit carries the carry, borrow or shifted-out bit
    logic [DATA_W:0] sum;
    logic            is_alu;

    always_comb begin
        sum    = '0;
        is_alu = 1'b1;
        case (op)
            OP_ADD:  sum = {1'b0, a} + {1'b0, b};
            OP_SUB:  sum = {1'b0, a} - {1'b0, b};  // wraps to set bit 16 on borrow
            OP_AND:  sum = {1'b0, a & b};
            OP_OR:   sum = {1'b0, a | b};
            OP_XOR:  sum = {1'b0, a ^ b};
            OP_NOT:  sum = {1'b0, ~a};
            OP_SHL:  sum = {a, 1'b0};
            OP_SHR:  sum = {a[0], 1'b0, a[DATA_W-1:1]};
            default: is_alu = 1'b0;
        endcase
    end

    assign result      = sum[DATA_W-1:0];
    assign flags.carry = sum[DATA_W];
    assign flags.zero  = is_alu && (result == '0);

endmodule

`default_nettype wire

// File: hdl/bat_amateur.sv
`timescale 1ns/10ps
`default_nettype none

module bat_amateur import bat_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              halt,
    input  wire logic              ext_ram_en,
    input  wire logic              ext_ram_rw,
    input  wire logic [MEM_AW-1:0] address,
    input  wire logic [DATA_W-1:0] data,
    output logic [DATA_W-1:0]      out,
    output logic [DATA_W-1:0]      rdata,
    output logic                   halted
);

    ctrl_t             ctrl;
    flags_t            alu_flags;
    instr_t            ir_q;
    logic [MEM_AW-1:0] pc_q;
    logic [MEM_AW-1:0] mar_q;
    logic              ram_acc_q;
    logic [DATA_W-1:0] bus;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] sel_data;
    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic              ram_en;
    logic              ram_we;
    logic [MEM_AW-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;

    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:  bus = {{(DATA_W-MEM_AW){1'b0}}, pc_q};
            BUS_RAM: bus = rdata;
            BUS_IMM: bus = {{(DATA_W-IMM_W){1'b0}}, ir_q.imm};
            BUS_REG: bus = sel_data;
            BUS_ALU: bus = alu_result;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q      <= '0;
            mar_q     <= '0;
            ir_q      <= '0;
            ram_acc_q <= 1'b0;
        end else begin
            if (ctrl.pc_load) begin
                pc_q <= bus[MEM_AW-1:0];
            end else if (ctrl.pc_inc) begin
                pc_q <= pc_q + 1'b1;
            end
            if (ctrl.mar_load) begin
                mar_q <= bus[MEM_AW-1:0];
            end
            if (ctrl.ir_load) begin
                ir_q <= instr_t'(bus);
            end
            // every MAR load is followed by one RAM access in fetch read, mem read or mem write
            ram_acc_q <= ctrl.mar_load;
        end
    end

    assign ram_en    = halt ? ext_ram_en : ram_acc_q;
    assign ram_we    = halt ? ext_ram_rw : ctrl.ram_we;
    assign ram_addr  = halt ? address : mar_q;
    assign ram_wdata = halt ? data : bus;

    bat_controller i_controller (
        .clk    (clk),
        .arst_n (arst_n),
        .halt   (halt),
        .flags  (alu_flags),
        .instr  (ir_q),
        .ctrl   (ctrl),
        .halted (halted),
        .flag_q ()
    );

    bat_alu i_alu (
        .a      (reg_a),
        .b      (reg_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    bat_regfile i_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .bus      (bus),
        .sel_data (sel_data),
        .reg_a    (reg_a),
        .reg_b    (reg_b),
        .reg_out  (out)
    );

    bat_memory i_memory (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: hdl/bat_controller.sv
`timescale 1ns/10ps
`default_nettype none

module bat_controller import bat_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   halt,
    input  wire flags_t flags,
    input  wire instr_t instr,
    output ctrl_t       ctrl,
    output logic        halted,
    output flags_t      flag_q
);

    state_e state;
    state_e state_nxt;
    ctrl_t  ctrl_dec;

    always_comb begin
        state_nxt = state;
        ctrl_dec  = '0;
        case (state)
            ST_FETCH_ADDR: begin
                ctrl_dec.bus_src  = BUS_PC;
                ctrl_dec.mar_load = 1'b1;
                state_nxt         = ST_FETCH_READ;
            end
            ST_FETCH_READ: begin
                state_nxt = ST_FETCH_IR;  // RAM registers the word at MAR here
            end
            ST_FETCH_IR: begin
                ctrl_dec.bus_src = BUS_RAM;
                ctrl_dec.ir_load = 1'b1;
                ctrl_dec.pc_inc  = 1'b1;
                state_nxt        = ST_EXEC;
            end
            ST_EXEC: begin
                state_nxt        = ST_FETCH_ADDR;
                ctrl_dec.reg_sel = instr.rd;
                case (instr.opcode)
                    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHL, OP_SHR: begin
                        ctrl_dec.bus_src  = BUS_ALU;
                        ctrl_dec.alu_op   = instr.opcode;
                        ctrl_dec.reg_we   = 1'b1;
                        ctrl_dec.flags_we = 1'b1;
                    end
                    OP_LDI: begin
                        ctrl_dec.bus_src = BUS_IMM;
                        ctrl_dec.reg_we  = 1'b1;
                    end
                    OP_MOV: begin
                        ctrl_dec.bus_src = BUS_REG;
                        ctrl_dec.src_sel = instr.imm[REG_IDX_W-1:0];
                        ctrl_dec.reg_we  = 1'b1;
                    end
                    OP_INC: begin
                        ctrl_dec.reg_inc = 1'b1;
                    end
                    OP_LD: begin
                        ctrl_dec.bus_src  = BUS_IMM;
                        ctrl_dec.mar_load = 1'b1;
                        state_nxt         = ST_MEM_READ;
                    end
                    OP_ST: begin
                        ctrl_dec.bus_src  = BUS_IMM;
                        ctrl_dec.mar_load = 1'b1;
                        state_nxt         = ST_MEM_WRITE;
                    end
                    OP_JMP, OP_JZ, OP_JC: begin
                        ctrl_dec.bus_src = BUS_IMM;
                        ctrl_dec.pc_load = (instr.opcode == OP_JMP) ||
                                           (instr.opcode == OP_JZ && flag_q.zero) ||
                                           (instr.opcode == OP_JC && flag_q.carry);
                    end
                    OP_HLT: begin
                        state_nxt = ST_HALTED;
                    end
                    OP_NOP: begin
                    end
                    default: begin
                    end
                endcase
            end
            ST_MEM_READ: begin
                state_nxt = ST_MEM_WB;
            end
            ST_MEM_WB: begin
                ctrl_dec.bus_src = BUS_RAM;
                ctrl_dec.reg_sel = instr.rd;
                ctrl_dec.reg_we  = 1'b1;
                state_nxt        = ST_FETCH_ADDR;
            end
            ST_MEM_WRITE: begin
                ctrl_dec.bus_src = BUS_REG;
                ctrl_dec.src_sel = instr.rd;
                ctrl_dec.ram_we  = 1'b1;
                state_nxt        = ST_FETCH_ADDR;
            end
            ST_HALTED: begin
                state_nxt = ST_HALTED;  // only halt gets us out
            end
            default: begin
                state_nxt = ST_FETCH_ADDR;
            end
        endcase
        if (halt) begin
            state_nxt = ST_FETCH_ADDR;
        end
    end

    assign ctrl   = halt ? '0 : ctrl_dec;  // outside world owns the RAM while halted
    assign halted = (state == ST_HALTED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_FETCH_ADDR;
            flag_q <= '0;
        end else begin
            state <= state_nxt;
            if (ctrl.flags_we) begin
                flag_q <= flags;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bat_memory.sv
`timescale 1ns/10ps
`default_nettype none

module bat_memory import bat_pkg::*; (
    input  wire logic              clk,
    input  wire logic              en,
    input  wire logic              we,
    input  wire logic [MEM_AW-1:0] addr,
    input  wire logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0]      rdata
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // read word shows one cycle later
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bat_pkg.sv
`default_nettype none

package bat_pkg;

    localparam int DATA_W    = 16;
    localparam int MEM_AW    = 8;
    localparam int MEM_DEPTH = 256;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = $clog2(NUM_REGS);
    localparam int IMM_W     = 8;

    localparam int REG_A   = 0;
    localparam int REG_B   = 1;
    localparam int REG_OUT = 7;

    // ALU ops share their codes with the ALU select
    typedef enum logic [4:0] {
        OP_NOP = 5'd0,
        OP_ADD = 5'd1,
        OP_SUB = 5'd2,
        OP_AND = 5'd3,
        OP_OR  = 5'd4,
        OP_XOR = 5'd5,
        OP_NOT = 5'd6,
        OP_SHL = 5'd7,
        OP_SHR = 5'd8,
        OP_LDI = 5'd9,
        OP_MOV = 5'd10,
        OP_INC = 5'd11,
        OP_LD  = 5'd12,
        OP_ST  = 5'd13,
        OP_JMP = 5'd14,
        OP_JZ  = 5'd15,
        OP_JC  = 5'd16,
        OP_HLT = 5'd17
    } opcode_e;

    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [IMM_W-1:0]     imm;
    } instr_t;

    typedef enum logic [2:0] {
        BUS_NONE = 3'd0,
        BUS_PC   = 3'd1,
        BUS_RAM  = 3'd2,
        BUS_IMM  = 3'd3,
        BUS_REG  = 3'd4,
        BUS_ALU  = 3'd5
    } bus_src_e;

    typedef struct packed {
        logic                 pc_inc;
        logic                 pc_load;
        logic                 mar_load;
        logic                 ram_we;
        logic                 ir_load;
        bus_src_e             bus_src;
        logic [REG_IDX_W-1:0] reg_sel;  // write target for reg_we and reg_inc
        logic [REG_IDX_W-1:0] src_sel;  // register put on the bus by BUS_REG
        logic                 reg_we;
        logic                 reg_inc;
        opcode_e              alu_op;
        logic                 flags_we;
    } ctrl_t;

    typedef struct packed {
        logic carry;
        logic zero;
    } flags_t;

    typedef enum logic [2:0] {
        ST_FETCH_ADDR,
        ST_FETCH_READ,
        ST_FETCH_IR,
        ST_EXEC,
        ST_MEM_READ,
        ST_MEM_WB,
        ST_MEM_WRITE,
        ST_HALTED
    } state_e;

endpackage

`default_nettype wire

// File: hdl/bat_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module bat_regfile import bat_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire ctrl_t             ctrl,
    input  wire logic [DATA_W-1:0] bus,
    output logic [DATA_W-1:0]      sel_data,
    output logic [DATA_W-1:0]      reg_a,
    output logic [DATA_W-1:0]      reg_b,
    output logic [DATA_W-1:0]      reg_out
);

    // A, B, 3 to 7, OUT from index 0 up
    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we) begin
            regs[ctrl.reg_sel] <= bus;
        end else if (ctrl.reg_inc) begin
            regs[ctrl.reg_sel] <= regs[ctrl.reg_sel] + 1'b1;  // wraps at 16 bits
        end
    end

    assign sel_data = regs[ctrl.src_sel];
    assign reg_a    = regs[REG_A];
    assign reg_b    = regs[REG_B];
    assign reg_out  = regs[REG_OUT];

endmodule

`default_nettype wire

// File: verif/bat_amateur_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module bat_amateur_assertions import bat_pkg::*; (
    input wire logic   clk,
    input wire logic   arst_n,
    input wire logic   halt,
    input wire ctrl_t  ctrl,
    input wire logic   halted,
    input wire state_e state
);

    logic strobes;

    assign strobes = ctrl.pc_inc | ctrl.pc_load | ctrl.mar_load | ctrl.ram_we | ctrl.ir_load |
                     ctrl.reg_we | ctrl.reg_inc | ctrl.flags_we;

    a_one_reg_update: assert property (@(posedge clk) disable iff (!arst_n)
        !(ctrl.reg_we && ctrl.reg_inc))
        else $error("reg_we and reg_inc are asserted together");

    a_ram_we_state: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.ram_we |-> state == ST_MEM_WRITE)
        else $error("ram_we is asserted outside ST_MEM_WRITE");

    a_halted_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !strobes)
        else $error("control strobes are active while halted");

    a_halt_restart: assert property (@(posedge clk) disable iff (!arst_n)
        halt |=> state == ST_FETCH_ADDR)
        else $error("halt did not return the controller to ST_FETCH_ADDR");

endmodule

bind bat_controller bat_amateur_assertions i_assertions (
    .clk    (clk),
    .arst_n (arst_n),
    .halt   (halt),
    .ctrl   (ctrl),
    .halted (halted),
    .state  (state)
);

`default_nettype wire

// File: verif/bat_amateur_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bat_amateur_tb import bat_pkg::*; ();

    logic              clk;
    logic              arst_n;
    logic              halt;
    logic              ext_ram_en;
    logic              ext_ram_rw;
    logic [MEM_AW-1:0] address;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] out;
    logic [DATA_W-1:0] rdata;
    logic              halted;

    bat_amateur i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .halt       (halt),
        .ext_ram_en (ext_ram_en),
        .ext_ram_rw (ext_ram_rw),
        .address    (address),
        .data       (data),
        .out        (out),
        .rdata      (rdata),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic write_word(input logic [MEM_AW-1:0] addr, input logic [DATA_W-1:0] value);
        @(posedge clk);
        ext_ram_en <= 1'b1;
        ext_ram_rw <= 1'b1;
        address    <= addr;
        data       <= value;
        @(posedge clk);  // the word lands on this edge
        ext_ram_en <= 1'b0;
        ext_ram_rw <= 1'b0;
    endtask

    task automatic read_word(input logic [MEM_AW-1:0] addr, input logic [DATA_W-1:0] expected);
        @(posedge clk);
        ext_ram_en <= 1'b1;
        ext_ram_rw <= 1'b0;
        address    <= addr;
        @(posedge clk);
        ext_ram_en <= 1'b0;
        @(negedge clk);
        check_value("rdata", rdata, expected);
    endtask

    // runs from the current PC until the program executes HLT
    task automatic run_program();
        int cycles;
        cycles = 0;
        @(posedge clk);
        halt <= 1'b0;
        @(negedge clk);
        while (!halted) begin
            if (cycles == 2000) begin
                $display("program did not reach HLT within 2000 cycles");
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        halt <= 1'b1;  // hand the RAM back to the testbench
        cycles = 0;
        @(negedge clk);
        while (halted) begin
            if (cycles == 4) begin
                $display("controller stayed halted after halt was raised");
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int                fd;
        int                code;
        string             line;
        string             args;
        logic [7:0]        kind;
        logic [MEM_AW-1:0] rec_addr;
        logic [DATA_W-1:0] rec_value;
        arst_n     = 1'b0;
        halt       = 1'b1;
        ext_ram_en = 1'b0;
        ext_ram_rw = 1'b0;
        address    = '0;
        data       = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("verif/bat_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/bat_stimulus.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            args = line.substr(1, line.len() - 1);
            case (kind)
                "L": begin
                    code = $sscanf(args, "%h %h", rec_addr, rec_value);
                    if (code != 2) begin
                        $display("load record without address and data: %s", line);
                        stop_with_failure();
                    end
                    write_word(rec_addr, rec_value);
                end
                "M": begin
                    code = $sscanf(args, "%h %h", rec_addr, rec_value);
                    if (code != 2) begin
                        $display("memory record without address and value: %s", line);
                        stop_with_failure();
                    end
                    read_word(rec_addr, rec_value);
                end
                "O": begin
                    code = $sscanf(args, "%h", rec_value);
                    if (code != 1) begin
                        $display("out record without a value: %s", line);
                        stop_with_failure();
                    end
                    @(negedge clk);
                    check_value("out", out, rec_value);
                end
                "R": run_program();
                "#", "\n", "\r", " ": begin
                end
                default: begin
                    $display("unknown record in the stimulus file: %s", line);
                    stop_with_failure();
                end
            endcase
        end
        $fclose(fd);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/bat_stimulus.txt
# L addr data writes RAM while halted, R runs to HLT, O value checks out
# M addr value reads RAM and checks rdata, all numbers are hex
L 80 1234
L 81 ABCD
L 82 8001
L 83 0007
M 80 1234
M 81 ABCD
L 00 4B5A
L 01 5703
L 02 8800
L 03 48F0
L 04 493C
L 05 0A00
L 06 1300
L 07 1C00
L 08 2500
L 09 2E00
L 0A 3700
L 0B 6A90
L 0C 6B91
L 0D 6C92
L 0E 6D93
L 0F 6E94
L 10 8800
L 11 6082
L 12 3F00
L 13 8016
L 14 4F11
L 15 8800
L 16 4F22
L 17 8800
L 18 4200
L 19 6A95
L 1A 6182
L 1B 1300
L 1C 8020
L 1D 7822
L 1E 4F33
L 1F 8800
L 20 4F44
L 21 8800
L 22 4F55
L 23 8800
L 24 6183
L 25 4F00
L 26 4800
L 27 5800
L 28 5F00
L 29 1200
L 2A 782C
L 2B 7027
L 2C 6F96
L 2D 8800
L 2E 6781
L 2F 8800
O 0000
R
O 005A
R
O FF0F
M 90 012C
M 91 00B4
M 92 0030
M 93 00FC
M 94 00CC
R
O 0022
R
O 0055
M 95 4000
R
O 0007
M 96 0007
R
O ABCD
